// ==== Bender.yml ====
package:
  name: rv64_core

export_include_dirs:
  - hw

sources:
  - include_dirs:
      - hw
    files:
      - hw/core_pkg.sv
      - hw/fetch_unit.sv
      - hw/memory_controller.sv
      - hw/icache.sv
      - hw/register_decode.sv
      - hw/alu.sv
      - hw/core_top.sv
  - target: test
    include_dirs:
      - hw
    files:
      - tb/core_tb_assertions.sv
      - tb/core_tb.sv

// ==== hw/alu.sv ====
`timescale 1ns/10ps

module alu (
  input  logic               clk,
  input  logic               reset,
  input  logic               dec_valid,
  input  core_pkg::alu_op_t  op,
  input  core_pkg::reg_idx_t rd,
  input  core_pkg::word_t    rs1_val,
  input  core_pkg::word_t    op2_val,   // rs2 or immediate
  input  core_pkg::word_t    dec_pc,
  // retire record, also the register write
  output logic               retire_valid,
  output core_pkg::word_t    retire_pc,
  output core_pkg::reg_idx_t retire_rd,
  output core_pkg::word_t    retire_data,
  output logic               retire_wr
);

  import core_pkg::*;

  word_t      result;
  logic [5:0] shamt;  // rv64 shifts use six bits

  assign shamt = op2_val[5:0];

  always_comb begin
    case (op)
      ALU_ADDI, ALU_ADD: result = rs1_val + op2_val;
      ALU_SUB:           result = rs1_val - op2_val;
      ALU_SLTI, ALU_SLT: result = word_t'($signed(rs1_val) < $signed(op2_val));
      ALU_SLTIU, ALU_SLTU: result = word_t'(rs1_val < op2_val);  // unsigned compare
      ALU_XORI, ALU_XOR: result = rs1_val ^ op2_val;
      ALU_ORI, ALU_OR:   result = rs1_val | op2_val;
      ALU_ANDI, ALU_AND: result = rs1_val & op2_val;
      ALU_SLLI, ALU_SLL: result = rs1_val << shamt;
      ALU_SRLI, ALU_SRL: result = rs1_val >> shamt;
      ALU_SRAI, ALU_SRA: result = word_t'($signed(rs1_val) >>> shamt);
      ALU_LUI:           result = op2_val;           // immediate already shifted up
      ALU_AUIPC:         result = dec_pc + op2_val;
      default:           result = '0;                // unsupported, not written
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      retire_valid <= 1'b0;
      retire_wr    <= 1'b0;
    end else begin
      retire_valid <= dec_valid;
      retire_wr    <= dec_valid && (op != ALU_NONE) && (rd != '0);  // x0 writes dropped here
    end
  end

  always_ff @(posedge clk) begin
    if (dec_valid) begin
      retire_pc   <= dec_pc;
      retire_rd   <= rd;
      retire_data <= result;
    end
  end

endmodule

// ==== hw/core_defs.svh ====
`ifndef CORE_DEFS_SVH
`define CORE_DEFS_SVH

// datapath widths
`define WORDSZ 64           // data and address width
`define INSTSZ 32           // instruction width
`define REGSZ 5             // register index width

// instruction cache geometry
`define BLOCKSZ 512         // one line, 64 bytes
`define BEATS 8             // bus beats per line
`define ICACHE_LINES 8

// system bus
`define BUS_DATA_WIDTH 64
`define BUS_TAG_WIDTH 13

// read request to memory: read bit, memory target, zero id
`define BUS_READ_TAG 13'h1100

`endif

// ==== hw/core_pkg.sv ====
`include "core_defs.svh"

package core_pkg;

  typedef logic [`WORDSZ-1:0] word_t;          // register value or address
  typedef logic [`REGSZ-1:0] reg_idx_t;        // x0..x31
  typedef logic [`INSTSZ-1:0] instr_t;
  typedef logic [`BLOCKSZ-1:0] block_t;        // one cache line
  typedef logic [`BUS_TAG_WIDTH-1:0] bus_tag_t;

  // operations the core executes, immediate and register forms kept apart
  typedef enum logic [4:0] {
    ALU_NONE,   // unsupported, retires without a write
    ALU_ADDI,
    ALU_SLTI,
    ALU_SLTIU,
    ALU_XORI,
    ALU_ORI,
    ALU_ANDI,
    ALU_SLLI,
    ALU_SRLI,
    ALU_SRAI,
    ALU_ADD,
    ALU_SUB,
    ALU_SLL,
    ALU_SLT,
    ALU_SLTU,
    ALU_XOR,
    ALU_SRL,
    ALU_SRA,
    ALU_OR,
    ALU_AND,
    ALU_LUI,
    ALU_AUIPC
  } alu_op_t;

endpackage

// ==== hw/core_top.sv ====
`timescale 1ns/10ps
`include "core_defs.svh"

module core_top (
  input  logic                       clk,
  input  logic                       reset,
  input  core_pkg::word_t            entry,      // program entry point
  input  core_pkg::word_t            stackptr,   // initial stack pointer
  // system bus
  output logic                       bus_reqcyc,
  output logic [`BUS_DATA_WIDTH-1:0] bus_req,
  output core_pkg::bus_tag_t         bus_reqtag,
  input  logic                       bus_reqack,
  input  logic                       bus_respcyc,
  input  logic [`BUS_DATA_WIDTH-1:0] bus_resp,
  input  core_pkg::bus_tag_t         bus_resptag,
  output logic                       bus_respack,
  // retire port
  output logic                       retire_valid,
  output core_pkg::word_t            retire_pc,
  output core_pkg::reg_idx_t         retire_rd,
  output core_pkg::word_t            retire_data,
  output logic                       retire_wr
);

  import core_pkg::*;

  word_t    pc;
  logic     fetch_strobe;
  instr_t   instr;
  logic     instr_valid;
  logic     mem_req;
  word_t    mem_addr;
  block_t   mem_block;
  logic     mem_block_valid;
  logic     dec_valid;
  alu_op_t  op;
  reg_idx_t rd;
  word_t    rs1_val;
  word_t    op2_val;
  word_t    dec_pc;

  fetch_unit fetch_unit_inst (
    .clk          (clk),
    .reset        (reset),
    .entry        (entry),
    .retire_valid (retire_valid),  // advance after each instruction
    .pc           (pc),
    .fetch_strobe (fetch_strobe)
  );

  icache icache_inst (
    .clk             (clk),
    .reset           (reset),
    .pc              (pc),
    .fetch_strobe    (fetch_strobe),
    .instr           (instr),
    .instr_valid     (instr_valid),
    .mem_req         (mem_req),
    .mem_addr        (mem_addr),
    .mem_block       (mem_block),
    .mem_block_valid (mem_block_valid)
  );

  memory_controller memory_controller_inst (
    .clk             (clk),
    .reset           (reset),
    .mem_req         (mem_req),
    .mem_addr        (mem_addr),
    .mem_block       (mem_block),
    .mem_block_valid (mem_block_valid),
    .bus_reqcyc      (bus_reqcyc),
    .bus_req         (bus_req),
    .bus_reqtag      (bus_reqtag),
    .bus_reqack      (bus_reqack),
    .bus_respcyc     (bus_respcyc),
    .bus_resp        (bus_resp),
    .bus_resptag     (bus_resptag),
    .bus_respack     (bus_respack)
  );

  // writeback goes straight from the alu retire register
  register_decode register_decode_inst (
    .clk          (clk),
    .reset        (reset),
    .stackptr     (stackptr),
    .instr        (instr),
    .instr_valid  (instr_valid),
    .prog_counter (pc),
    .wr_en        (retire_wr),
    .wr_reg       (retire_rd),
    .wr_data      (retire_data),
    .dec_valid    (dec_valid),
    .op           (op),
    .rd           (rd),
    .rs1_val      (rs1_val),
    .op2_val      (op2_val),
    .dec_pc       (dec_pc)
  );

  alu alu_inst (
    .clk          (clk),
    .reset        (reset),
    .dec_valid    (dec_valid),
    .op           (op),
    .rd           (rd),
    .rs1_val      (rs1_val),
    .op2_val      (op2_val),
    .dec_pc       (dec_pc),
    .retire_valid (retire_valid),
    .retire_pc    (retire_pc),
    .retire_rd    (retire_rd),
    .retire_data  (retire_data),
    .retire_wr    (retire_wr)
  );

endmodule

// ==== hw/fetch_unit.sv ====
`timescale 1ns/10ps

module fetch_unit (
  input  logic            clk,
  input  logic            reset,
  input  core_pkg::word_t entry,         // first pc after reset
  input  logic            retire_valid,  // previous instruction finished
  output core_pkg::word_t pc,
  output logic            fetch_strobe
);

  logic started;  // first strobe already sent

  // only one instruction is in flight, so the pc moves on retire alone
  always_ff @(posedge clk) begin
    if (reset) begin
      pc           <= entry;
      started      <= 1'b0;
      fetch_strobe <= 1'b0;
    end else begin
      started      <= 1'b1;
      fetch_strobe <= ~started | retire_valid;  // kick off once, then after every retire
      if (retire_valid) begin
        pc <= pc + 64'd4;  // straight-line code only
      end
    end
  end

endmodule

// ==== hw/icache.sv ====
`timescale 1ns/10ps
`include "core_defs.svh"

module icache (
  input  logic             clk,
  input  logic             reset,
  // fetch side
  input  core_pkg::word_t  pc,
  input  logic             fetch_strobe,
  output core_pkg::instr_t instr,
  output logic             instr_valid,
  // refill side
  output logic             mem_req,
  output core_pkg::word_t  mem_addr,
  input  core_pkg::block_t mem_block,
  input  logic             mem_block_valid
);

  import core_pkg::*;

  localparam int OFFSET_BITS = $clog2(`BLOCKSZ / 8);  // byte offset in a line
  localparam int INDEX_BITS  = $clog2(`ICACHE_LINES);
  localparam int TAG_BITS    = `WORDSZ - INDEX_BITS - OFFSET_BITS;
  localparam int SEL_BITS    = OFFSET_BITS - 2;       // instruction within a line

  block_t                    lines [`ICACHE_LINES];
  logic [TAG_BITS-1:0]       tags  [`ICACHE_LINES];
  logic [`ICACHE_LINES-1:0]  valid;

  logic [INDEX_BITS-1:0]     index;
  logic [TAG_BITS-1:0]       tag;
  logic [SEL_BITS-1:0]       word_sel;
  logic                      hit;
  logic                      miss_pending;  // refill outstanding

  // pc stays put until retire, so it still addresses the line during a refill
  assign index    = pc[OFFSET_BITS +: INDEX_BITS];
  assign tag      = pc[`WORDSZ-1 -: TAG_BITS];
  assign word_sel = pc[OFFSET_BITS-1:2];
  assign hit      = valid[index] && (tags[index] == tag);

  function automatic instr_t select_word(block_t blk, logic [SEL_BITS-1:0] sel);
    return blk[sel * `INSTSZ +: `INSTSZ];  // little endian, word 0 at bit 0
  endfunction

  // control
  always_ff @(posedge clk) begin
    if (reset) begin
      valid        <= '0;  // cache starts empty
      miss_pending <= 1'b0;
      mem_req      <= 1'b0;
      instr_valid  <= 1'b0;
    end else begin
      mem_req     <= 1'b0;
      instr_valid <= 1'b0;
      if (fetch_strobe && !miss_pending) begin
        if (hit) begin
          instr_valid <= 1'b1;
        end else begin
          mem_req      <= 1'b1;  // one pulse per miss
          miss_pending <= 1'b1;
        end
      end
      if (miss_pending && mem_block_valid) begin
        valid[index] <= 1'b1;
        miss_pending <= 1'b0;
        instr_valid  <= 1'b1;  // deliver straight from the refill
      end
    end
  end

  // line storage and instruction register
  always_ff @(posedge clk) begin
    if (fetch_strobe && !miss_pending) begin
      if (hit) begin
        instr <= select_word(lines[index], word_sel);
      end else begin
        mem_addr <= {pc[`WORDSZ-1:OFFSET_BITS], {OFFSET_BITS{1'b0}}};  // aligned block
      end
    end
    if (miss_pending && mem_block_valid) begin
      lines[index] <= mem_block;
      tags[index]  <= tag;
      instr        <= select_word(mem_block, word_sel);
    end
  end

endmodule

// ==== hw/memory_controller.sv ====
`timescale 1ns/10ps
`include "core_defs.svh"

module memory_controller (
  input  logic                         clk,
  input  logic                         reset,
  // block read from the icache
  input  logic                         mem_req,
  input  core_pkg::word_t              mem_addr,     // 64-byte aligned
  output core_pkg::block_t             mem_block,
  output logic                         mem_block_valid,
  // system bus
  output logic                         bus_reqcyc,
  output logic [`BUS_DATA_WIDTH-1:0]   bus_req,
  output core_pkg::bus_tag_t           bus_reqtag,
  input  logic                         bus_reqack,
  input  logic                         bus_respcyc,
  input  logic [`BUS_DATA_WIDTH-1:0]   bus_resp,
  input  core_pkg::bus_tag_t           bus_resptag,
  output logic                         bus_respack
);

  localparam int CNT_BITS = $clog2(`BEATS);

  typedef enum logic [1:0] {
    IDLE,     // waiting for a miss
    REQUEST,  // address on the bus until acked
    COLLECT   // gathering response beats
  } state_t;

  state_t              state;
  logic [CNT_BITS-1:0] beat_cnt;  // accepted beats so far

  assign bus_reqtag = `BUS_READ_TAG;  // only block reads are issued

  // a beat is ours only while collecting and only with the read tag
  assign bus_respack = (state == COLLECT) && bus_respcyc && (bus_resptag == `BUS_READ_TAG);

  always_ff @(posedge clk) begin
    if (reset) begin
      state           <= IDLE;
      beat_cnt        <= '0;
      bus_reqcyc      <= 1'b0;
      mem_block_valid <= 1'b0;
    end else begin
      mem_block_valid <= 1'b0;
      case (state)
        IDLE: begin
          if (mem_req) begin
            bus_reqcyc <= 1'b1;
            state      <= REQUEST;
          end
        end
        REQUEST: begin
          if (bus_reqack) begin  // seen at this edge, drop next cycle
            bus_reqcyc <= 1'b0;
            beat_cnt   <= '0;
            state      <= COLLECT;
          end
        end
        COLLECT: begin
          if (bus_respack) begin
            beat_cnt <= beat_cnt + 1'b1;
            if (beat_cnt == CNT_BITS'(`BEATS - 1)) begin
              mem_block_valid <= 1'b1;  // block complete after the last shift
              state           <= IDLE;
            end
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  // address and block data
  always_ff @(posedge clk) begin
    if (state == IDLE && mem_req) begin
      bus_req <= mem_addr;
    end
    if (bus_respack) begin
      // low word arrives first, so shift in from the top
      mem_block <= {bus_resp, mem_block[`BLOCKSZ-1:`BUS_DATA_WIDTH]};
    end
  end

endmodule

// ==== hw/register_decode.sv ====
`timescale 1ns/10ps
`include "core_defs.svh"

module register_decode (
  input  logic               clk,
  input  logic               reset,
  input  core_pkg::word_t    stackptr,      // initial x2
  // instruction from the icache
  input  core_pkg::instr_t   instr,
  input  logic               instr_valid,
  input  core_pkg::word_t    prog_counter,
  // register write from the alu
  input  logic               wr_en,
  input  core_pkg::reg_idx_t wr_reg,
  input  core_pkg::word_t    wr_data,
  // decoded instruction
  output logic               dec_valid,
  output core_pkg::alu_op_t  op,
  output core_pkg::reg_idx_t rd,
  output core_pkg::word_t    rs1_val,
  output core_pkg::word_t    op2_val,
  output core_pkg::word_t    dec_pc
);

  import core_pkg::*;

  localparam int NREGS = 1 << `REGSZ;

  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_AUIPC  = 7'b0010111;

  word_t    regs [NREGS];  // x0 is never written and stays zero
  alu_op_t  op_next;
  word_t    op2_next;
  word_t    imm_i;
  word_t    imm_u;
  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  reg_idx_t rs1;
  reg_idx_t rs2;

  assign opcode = instr[6:0];
  assign funct3 = instr[14:12];
  assign funct7 = instr[31:25];
  assign rs1    = instr[19:15];
  assign rs2    = instr[24:20];
  assign imm_i  = {{(`WORDSZ-12){instr[31]}}, instr[31:20]};
  assign imm_u  = {{(`WORDSZ-32){instr[31]}}, instr[31:12], 12'b0};

  always_comb begin
    op_next  = ALU_NONE;
    op2_next = imm_i;  // shifts use its low six bits as shamt
    case (opcode)
      OPC_OP_IMM: begin
        case (funct3)
          3'b000: op_next = ALU_ADDI;
          3'b010: op_next = ALU_SLTI;
          3'b011: op_next = ALU_SLTIU;
          3'b100: op_next = ALU_XORI;
          3'b110: op_next = ALU_ORI;
          3'b111: op_next = ALU_ANDI;
          3'b001: if (instr[31:26] == 6'b000000) op_next = ALU_SLLI;
          3'b101: begin
            if (instr[31:26] == 6'b000000) op_next = ALU_SRLI;
            else if (instr[31:26] == 6'b010000) op_next = ALU_SRAI;
          end
          default: op_next = ALU_NONE;
        endcase
      end
      OPC_OP: begin
        op2_next = regs[rs2];
        if (funct7 == 7'b0000000) begin
          case (funct3)
            3'b000: op_next = ALU_ADD;
            3'b001: op_next = ALU_SLL;
            3'b010: op_next = ALU_SLT;
            3'b011: op_next = ALU_SLTU;
            3'b100: op_next = ALU_XOR;
            3'b101: op_next = ALU_SRL;
            3'b110: op_next = ALU_OR;
            default: op_next = ALU_AND;
          endcase
        end else if (funct7 == 7'b0100000) begin
          if (funct3 == 3'b000) op_next = ALU_SUB;
          else if (funct3 == 3'b101) op_next = ALU_SRA;
        end
      end
      OPC_LUI: begin
        op_next  = ALU_LUI;
        op2_next = imm_u;
      end
      OPC_AUIPC: begin
        op_next  = ALU_AUIPC;
        op2_next = imm_u;
      end
      default: op_next = ALU_NONE;  // loads, stores, branches and the rest
    endcase
  end

  // register file, written at the end of the retire cycle
  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < NREGS; i++) begin
        regs[i] <= (i == 2) ? stackptr : '0;
      end
    end else if (wr_en && wr_reg != '0) begin
      regs[wr_reg] <= wr_data;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      dec_valid <= 1'b0;
    end else begin
      dec_valid <= instr_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (instr_valid) begin
      op      <= op_next;
      rd      <= instr[11:7];
      rs1_val <= regs[rs1];
      op2_val <= op2_next;
      dec_pc  <= prog_counter;
    end
  end

endmodule

// ==== tb.f ====
+incdir+hw
hw/core_pkg.sv
hw/fetch_unit.sv
hw/memory_controller.sv
hw/icache.sv
hw/register_decode.sv
hw/alu.sv
hw/core_top.sv
tb/core_tb_assertions.sv
tb/core_tb.sv

// ==== tb/core_tb.sv ====
`timescale 1ns/10ps
`include "core_defs.svh"

module core_tb;

  import core_pkg::*;

  localparam int       PROG_LEN        = 160;
  localparam int       WATCHDOG_CYCLES = PROG_LEN * 40 + 200;  // misses stay well under 40
  localparam word_t    ENTRY           = 64'h0000_0000_8000_0010;  // starts mid-line
  localparam word_t    STACKPTR        = 64'h0000_003f_fff0_0000;
  localparam bus_tag_t FOREIGN_TAG     = 13'h0042;  // some other master's response

  logic                       clk = 1'b0;
  logic                       reset;
  word_t                      entry;
  word_t                      stackptr;
  logic                       bus_reqcyc;
  logic [`BUS_DATA_WIDTH-1:0] bus_req;
  bus_tag_t                   bus_reqtag;
  logic                       bus_reqack;
  logic                       bus_respcyc;
  logic [`BUS_DATA_WIDTH-1:0] bus_resp;
  bus_tag_t                   bus_resptag;
  logic                       bus_respack;
  logic                       retire_valid;
  word_t                      retire_pc;
  reg_idx_t                   retire_rd;
  word_t                      retire_data;
  logic                       retire_wr;

  integer      seed;
  instr_t      prog [PROG_LEN];
  word_t       model_regs [32];  // architectural state of the reference model
  word_t       exp_pc;
  int          retired = 0;
  // bus model state
  int          phase;      // 0 idle, 1 ack delay, 2 ack on the bus, 3 beats
  int          wait_cnt;
  int          beat;
  word_t       req_addr;
  word_t       next_line;  // straight-line code asks for lines in order
  int          req_count = 0;
  logic [31:0] r;

  always #50 clk = ~clk;

  core_top core_top_inst (
    .clk          (clk),
    .reset        (reset),
    .entry        (entry),
    .stackptr     (stackptr),
    .bus_reqcyc   (bus_reqcyc),
    .bus_req      (bus_req),
    .bus_reqtag   (bus_reqtag),
    .bus_reqack   (bus_reqack),
    .bus_respcyc  (bus_respcyc),
    .bus_resp     (bus_resp),
    .bus_resptag  (bus_resptag),
    .bus_respack  (bus_respack),
    .retire_valid (retire_valid),
    .retire_pc    (retire_pc),
    .retire_rd    (retire_rd),
    .retire_data  (retire_data),
    .retire_wr    (retire_wr)
  );

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("*** FAILED ***");
    $fatal(1);
  endtask

  task automatic check_word(input string name, input word_t got, input word_t exp);
    if (got !== exp)
      abort_run($sformatf("FAIL at %0t: %s = %h, expected %h", $time, name, got, exp));
  endtask

  task automatic check_reg(input string name, input reg_idx_t got, input reg_idx_t exp);
    if (got !== exp)
      abort_run($sformatf("FAIL at %0t: %s = %0d, expected %0d", $time, name, got, exp));
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp)
      abort_run($sformatf("FAIL at %0t: %s = %b, expected %b", $time, name, got, exp));
  endtask

  task automatic check_tag(input string name, input bus_tag_t got, input bus_tag_t exp);
    if (got !== exp)
      abort_run($sformatf("FAIL at %0t: %s = %h, expected %h", $time, name, got, exp));
  endtask

  // program words inside the image, an address hash everywhere else
  function automatic instr_t mem_word(input word_t addr);
    word_t off;
    off = addr - ENTRY;
    if (addr >= ENTRY && off < 4 * PROG_LEN)
      return prog[off[31:2]];
    return addr[31:0] ^ addr[63:32] ^ 32'h6b5d_0f13;
  endfunction

  // kinds 0..20 are the kept ops in order, 21..23 are unsupported words
  function automatic instr_t make_instr(input int kind, input logic [31:0] r);
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [11:0] imm;
    rd  = r[4:0];
    rs1 = r[9:5];
    rs2 = r[14:10];
    imm = r[31:20];
    case (kind)
      0:  return {imm, rs1, 3'b000, rd, 7'b0010011};
      1:  return {imm, rs1, 3'b010, rd, 7'b0010011};
      2:  return {imm, rs1, 3'b011, rd, 7'b0010011};
      3:  return {imm, rs1, 3'b100, rd, 7'b0010011};
      4:  return {imm, rs1, 3'b110, rd, 7'b0010011};
      5:  return {imm, rs1, 3'b111, rd, 7'b0010011};
      6:  return {6'b000000, r[25:20], rs1, 3'b001, rd, 7'b0010011};  // slli
      7:  return {6'b000000, r[25:20], rs1, 3'b101, rd, 7'b0010011};  // srli
      8:  return {6'b010000, r[25:20], rs1, 3'b101, rd, 7'b0010011};  // srai
      9:  return {7'b0000000, rs2, rs1, 3'b000, rd, 7'b0110011};
      10: return {7'b0100000, rs2, rs1, 3'b000, rd, 7'b0110011};      // sub
      11: return {7'b0000000, rs2, rs1, 3'b001, rd, 7'b0110011};
      12: return {7'b0000000, rs2, rs1, 3'b010, rd, 7'b0110011};
      13: return {7'b0000000, rs2, rs1, 3'b011, rd, 7'b0110011};
      14: return {7'b0000000, rs2, rs1, 3'b100, rd, 7'b0110011};
      15: return {7'b0000000, rs2, rs1, 3'b101, rd, 7'b0110011};
      16: return {7'b0100000, rs2, rs1, 3'b101, rd, 7'b0110011};      // sra
      17: return {7'b0000000, rs2, rs1, 3'b110, rd, 7'b0110011};
      18: return {7'b0000000, rs2, rs1, 3'b111, rd, 7'b0110011};
      19: return {r[31:12], rd, 7'b0110111};                         // lui
      20: return {r[31:12], rd, 7'b0010111};                         // auipc
      21: return {imm, rs1, 3'b011, rd, 7'b0000011};                 // ld
      22: return {7'b0000001, rs2, rs1, 3'b000, rd, 7'b0110011};      // mul
      default: return {imm, rs1, 3'b000, rd, 7'b1100011};            // branch
    endcase
  endfunction

  // rv64i semantics for the kept subset, write flag as return value
  function automatic logic ref_exec(input instr_t ins, input word_t pc,
                                    input word_t regs [32],
                                    output reg_idx_t rd, output word_t value);
    word_t a;
    word_t b;
    word_t imm_i;
    word_t imm_u;
    logic  ok;
    a     = regs[ins[19:15]];
    b     = regs[ins[24:20]];
    imm_i = {{52{ins[31]}}, ins[31:20]};
    imm_u = {{32{ins[31]}}, ins[31:12], 12'h000};
    rd    = ins[11:7];
    value = '0;  // unsupported words retire with zero data
    ok    = 1'b1;
    case (ins[6:0])
      7'b0010011: begin
        case (ins[14:12])
          3'b000: value = a + imm_i;
          3'b010: value = ($signed(a) < $signed(imm_i)) ? 64'd1 : 64'd0;
          3'b011: value = (a < imm_i) ? 64'd1 : 64'd0;
          3'b100: value = a ^ imm_i;
          3'b110: value = a | imm_i;
          3'b111: value = a & imm_i;
          3'b001: begin
            if (ins[31:26] == 6'b000000) value = a << ins[25:20];
            else ok = 1'b0;
          end
          default: begin
            if (ins[31:26] == 6'b000000) value = a >> ins[25:20];
            else if (ins[31:26] == 6'b010000) value = $signed(a) >>> ins[25:20];
            else ok = 1'b0;
          end
        endcase
      end
      7'b0110011: begin
        if (ins[31:25] == 7'b0000000) begin
          case (ins[14:12])
            3'b000: value = a + b;
            3'b001: value = a << b[5:0];
            3'b010: value = ($signed(a) < $signed(b)) ? 64'd1 : 64'd0;
            3'b011: value = (a < b) ? 64'd1 : 64'd0;
            3'b100: value = a ^ b;
            3'b101: value = a >> b[5:0];
            3'b110: value = a | b;
            default: value = a & b;
          endcase
        end else if (ins[31:25] == 7'b0100000 && ins[14:12] == 3'b000) begin
          value = a - b;
        end else if (ins[31:25] == 7'b0100000 && ins[14:12] == 3'b101) begin
          value = $signed(a) >>> b[5:0];
        end else begin
          ok = 1'b0;
        end
      end
      7'b0110111: value = imm_u;
      7'b0010111: value = pc + imm_u;
      default: ok = 1'b0;
    endcase
    return ok && (rd != 5'd0);
  endfunction

  initial begin
    seed        = 32'hffaa67e5;
    reset       = 1'b1;
    entry       = ENTRY;
    stackptr    = STACKPTR;
    bus_reqack  = 1'b0;
    bus_respcyc = 1'b0;
    bus_resp    = '0;
    bus_resptag = '0;
    exp_pc      = ENTRY;
    next_line   = {ENTRY[63:6], 6'b0};
    for (int i = 0; i < 32; i++) model_regs[i] = (i == 2) ? STACKPTR : '0;
    // first two read x2 and an untouched register before anything is written
    prog[0] = {12'h000, 5'd2, 3'b000, 5'd5, 7'b0010011};          // addi x5, x2, 0
    prog[1] = {7'b0000000, 5'd2, 5'd7, 3'b000, 5'd6, 7'b0110011};  // add x6, x7, x2
    for (int i = 2; i < PROG_LEN; i++) begin
      r = $random(seed);
      prog[i] = make_instr((i < 26) ? i - 2 : $unsigned($random(seed)) % 24, r);
    end
    repeat (2) @(posedge clk);
    check_bit("bus_reqcyc", bus_reqcyc, 1'b0);
    check_bit("bus_respack", bus_respack, 1'b0);
    check_bit("retire_valid", retire_valid, 1'b0);
    check_bit("retire_wr", retire_wr, 1'b0);
    reset <= 1'b0;
  end

  // bus slave: random ack delay, gaps and foreign beats between the eight read beats
  always @(posedge clk) begin
    if (reset) begin
      bus_reqack  <= 1'b0;
      bus_respcyc <= 1'b0;
      phase = 0;
    end else begin
      if (phase == 0) begin
        if (bus_reqcyc) begin
          req_addr = bus_req;
          if (req_addr[5:0] != 6'b0) abort_run("bus request address is not line aligned");
          check_word("bus_req", req_addr, next_line);
          check_tag("bus_reqtag", bus_reqtag, `BUS_READ_TAG);
          next_line = next_line + 64;
          req_count <= req_count + 1;
          wait_cnt = $unsigned($random(seed)) % 4;
          phase = 1;
        end
      end else if (phase == 1) begin
        if (!bus_reqcyc) abort_run("bus request dropped before it was acknowledged");
        if (wait_cnt == 0) begin
          bus_reqack <= 1'b1;
          phase = 2;
        end else begin
          wait_cnt = wait_cnt - 1;
        end
      end else if (phase == 2) begin  // controller sees the ack at this edge
        bus_reqack <= 1'b0;
        beat = 0;
        phase = 3;
      end else if (bus_respcyc) begin  // settle the beat of the last cycle
        if (bus_resptag == `BUS_READ_TAG) begin
          if (!bus_respack) abort_run("read beat was not acknowledged");
          beat = beat + 1;
        end else if (bus_respack) begin
          abort_run("beat with a foreign tag was acknowledged");
        end
      end
      if (phase == 3) begin
        r = $random(seed);
        if (beat == `BEATS) begin
          bus_respcyc <= 1'b0;
          phase = 0;
        end else if (r[1:0] == 2'b00) begin
          bus_respcyc <= 1'b0;  // gap
        end else if (r[4:2] == 3'b000) begin
          bus_respcyc <= 1'b1;
          bus_resptag <= FOREIGN_TAG;
          bus_resp    <= {r, ~r};  // junk that must not land in the line
        end else begin
          bus_respcyc <= 1'b1;
          bus_resptag <= `BUS_READ_TAG;
          bus_resp    <= {mem_word(req_addr + 8 * beat + 4), mem_word(req_addr + 8 * beat)};
        end
      end
    end
  end

  // compare every retire with the reference model
  always @(posedge clk) begin
    reg_idx_t exp_rd;
    word_t    exp_data;
    logic     exp_wr;
    if (!reset && retire_valid) begin
      check_word("retire_pc", retire_pc, exp_pc);
      exp_wr = ref_exec(prog[retired], exp_pc, model_regs, exp_rd, exp_data);
      check_reg("retire_rd", retire_rd, exp_rd);
      check_word("retire_data", retire_data, exp_data);
      check_bit("retire_wr", retire_wr, exp_wr);
      if (exp_wr) model_regs[exp_rd] = exp_data;
      exp_pc  = exp_pc + 4;
      retired = retired + 1;
      if (retired == PROG_LEN) begin
        // one refill per line touched by the straight-line program
        if (req_count != ((exp_pc - 4) >> 6) - (ENTRY >> 6) + 1) begin
          abort_run($sformatf("%0d bus requests, one per executed line expected", req_count));
        end else begin
          $display("*** PASSED ***");
          $finish;
        end
      end
    end
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    abort_run($sformatf("timeout with %0d of %0d instructions retired", retired, PROG_LEN));
  end

endmodule

// ==== tb/core_tb_assertions.sv ====
`timescale 1ns/10ps
`include "core_defs.svh"

module core_tb_assertions (
  input logic                       clk,
  input logic                       reset,
  input logic                       bus_reqcyc,
  input logic                       bus_reqack,
  input logic [`BUS_DATA_WIDTH-1:0] bus_req,
  input core_pkg::bus_tag_t         bus_reqtag,
  input logic                       bus_respcyc,
  input logic                       bus_respack,
  input logic                       retire_valid,
  input core_pkg::reg_idx_t         retire_rd,
  input logic                       retire_wr
);

  // an unacked request keeps cyc, address and tag
  assert property (@(posedge clk) disable iff (reset)
      bus_reqcyc && !bus_reqack |=> bus_reqcyc && $stable(bus_req) && $stable(bus_reqtag))
    else $error("bus request changed while waiting for bus_reqack");

  // ack only a beat that is on the bus
  assert property (@(posedge clk) disable iff (reset) bus_respack |-> bus_respcyc)
    else $error("bus_respack without bus_respcyc");

  assert property (@(posedge clk) disable iff (reset)
      retire_wr |-> retire_valid && (retire_rd != '0))  // x0 never written
    else $error("retire_wr outside a retire or for x0");

endmodule

bind core_top core_tb_assertions core_tb_assertions_inst (.*);
